// ==== rtl/lane_game_settings.svh ====
`ifndef LANE_GAME_SETTINGS_SVH
`define LANE_GAME_SETTINGS_SVH

// bus widths
`define LG_COORD_W 10
`define LG_RGB_W 12
`define LG_SCORE_W 16

// 12-bit rgb colours, 4 bits per channel
`define LG_BLACK 12'h000
`define LG_WHITE 12'hFFF
`define LG_RED 12'hF00
`define LG_GREEN 12'h0F0
`define LG_BLUE 12'h468
`define LG_SAND 12'hECA

// hCount of the first visible pixel
`define LG_H_VISIBLE_START 10'd144

// playfield spans screen x 140 to 500
`define LG_SAND_LEFT (`LG_H_VISIBLE_START + 10'd140)
`define LG_SAND_RIGHT (`LG_H_VISIBLE_START + 10'd500)

// lane centres, 140 pixels apart
`define LG_LANE0_X (`LG_H_VISIBLE_START + 10'd180)
`define LG_LANE1_X (`LG_H_VISIBLE_START + 10'd320)
`define LG_LANE2_X (`LG_H_VISIBLE_START + 10'd460)

// object geometry
`define LG_PLAYER_Y_START 10'd400
`define LG_PLAYER_HEIGHT 10'd80
`define LG_HALF_W 10'd40
`define LG_ROCK_HEIGHT 10'd80
`define LG_SCREEN_BOTTOM 10'd479

// motion per slow tick
`define LG_ROCK_STEP 10'd4
`define LG_BOAT_STEP 10'd5

// start values
`define LG_LFSR_SEED 8'hAC
`define LG_ROCK0_START_LANE 2'd0
`define LG_ROCK1_START_LANE 2'd2
`define LG_ROCK1_START_Y 10'd80

`endif

// ==== rtl/lane_game_pkg.sv ====
`include "lane_game_settings.svh"

package lane_game_pkg;

    // lane 0 is left, 2 is right
    typedef logic [1:0] lane_t;
    typedef logic [`LG_COORD_W-1:0] coord_t;
    typedef logic [`LG_RGB_W-1:0] rgb_t;

    typedef enum logic [1:0] {
        START,
        PLAY,
        GAMEOVER
    } game_state_e;

    // beam position in hCount and vCount terms
    typedef struct packed {
        coord_t h;
        coord_t v;
    } beam_t;

    // one rock, y is its top edge
    typedef struct packed {
        lane_t lane;
        coord_t y;
    } rock_t;

    typedef struct packed {
        rock_t rock0;
        rock_t rock1;
    } rock_pair_t;

    // plain button levels
    typedef struct packed {
        logic left;
        logic right;
        logic centre;
    } buttons_t;

    // lane number to centre x, lane 3 falls back to the middle
    function automatic coord_t lane_center(input lane_t lane);
        case (lane)
            2'd0: return `LG_LANE0_X;
            2'd2: return `LG_LANE2_X;
            default: return `LG_LANE1_X;
        endcase
    endfunction

endpackage

// ==== rtl/game_ctrl.sv ====
`include "lane_game_settings.svh"

module game_ctrl
    import lane_game_pkg::*;
#(
    parameter int TICK_BITS = 22
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  buttons_t               buttons,
    input  coord_t                 boat_x,
    input  rock_pair_t             rocks,
    input  logic                   wave,
    output logic                   tick,
    output game_state_e            state,
    output logic                   collision,
    output logic [`LG_SCORE_W-1:0] score
);

    localparam coord_t PLAYER_Y_END = `LG_PLAYER_Y_START + `LG_PLAYER_HEIGHT;

    logic [TICK_BITS-1:0] tick_cnt;
    coord_t               player_left;
    coord_t               player_right;
    logic                 hit0;
    logic                 hit1;

    // slow tick, counter wraps every 2^TICK_BITS clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign tick = (tick_cnt == '0);

    // player box edges
    assign player_left  = boat_x - `LG_HALF_W;
    assign player_right = boat_x + `LG_HALF_W;

    // overlap test with inclusive edges, touching counts
    function automatic logic overlaps(input rock_t r, input coord_t pl, input coord_t pr);
        coord_t cx;
        logic   x_ov;
        logic   y_ov;
        cx   = lane_center(r.lane);
        x_ov = (pr >= cx - `LG_HALF_W) && (pl <= cx + `LG_HALF_W);
        y_ov = (PLAYER_Y_END >= r.y) && (`LG_PLAYER_Y_START <= r.y + `LG_ROCK_HEIGHT);
        return x_ov && y_ov;
    endfunction

    assign hit0      = overlaps(rocks.rock0, player_left, player_right);
    assign hit1      = overlaps(rocks.rock1, player_left, player_right);
    assign collision = hit0 | hit1;

    // game state, centre always wins over collision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= START;
        end else begin
            case (state)
                START:    if (buttons.centre) state <= PLAY;
                PLAY: begin
                    if (buttons.centre)
                        state <= START;
                    else if (collision)
                        state <= GAMEOVER;
                end
                GAMEOVER: if (buttons.centre) state <= START;
                default:  state <= START;
            endcase
        end
    end

    // one point per rock wave, only while playing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            score <= '0;
        else if (state == START)
            score <= '0;
        else if (state == PLAY && wave)
            score <= score + 1'b1;
    end

endmodule

// ==== rtl/boat_steer.sv ====
`include "lane_game_settings.svh"

module boat_steer
    import lane_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  game_state_e state,
    input  logic        tick,
    input  buttons_t    buttons,
    output coord_t      boat_x
);

    // steering machine, READY takes buttons and MOVING slides
    typedef enum logic {
        READY,
        MOVING
    } steer_e;

    steer_e steer;
    lane_t  lane;
    coord_t target_x;

    // centre of the lane we are heading for
    assign target_x = lane_center(lane);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            steer  <= READY;
            lane   <= 2'd1;
            boat_x <= `LG_LANE1_X;
        end else begin
            case (state)
                START: begin
                    // back to the middle lane
                    steer  <= READY;
                    lane   <= 2'd1;
                    boat_x <= `LG_LANE1_X;
                end
                PLAY: begin
                    if (steer == READY) begin
                        // locked on the lane centre
                        boat_x <= target_x;
                        // left wins when both are held
                        if (buttons.left && lane > 2'd0) begin
                            lane  <= lane - 2'd1;
                            steer <= MOVING;
                        end else if (buttons.right && lane < 2'd2) begin
                            lane  <= lane + 2'd1;
                            steer <= MOVING;
                        end
                    end else begin
                        // one step per tick toward target
                        if (tick) begin
                            if (boat_x < target_x)
                                boat_x <= boat_x + `LG_BOAT_STEP;
                            else if (boat_x > target_x)
                                boat_x <= boat_x - `LG_BOAT_STEP;
                        end
                        // arrived, take buttons again
                        if (boat_x == target_x)
                            steer <= READY;
                    end
                end
                // frozen in game over
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/rock_field.sv ====
`include "lane_game_settings.svh"

module rock_field
    import lane_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  game_state_e state,
    input  logic        tick,
    output rock_pair_t  rocks,
    output logic        wave
);

    // rock leaves the screen once its top passes this row
    localparam coord_t ROCK_LIMIT = `LG_SCREEN_BOTTOM + `LG_ROCK_HEIGHT;

    // start layout, left lane at the top and right lane lower
    localparam rock_pair_t ROCKS_INIT = '{
        rock0: '{lane: `LG_ROCK0_START_LANE, y: '0},
        rock1: '{lane: `LG_ROCK1_START_LANE, y: `LG_ROCK1_START_Y}
    };

    logic [7:0] lfsr;
    logic       wrap0;
    logic       wrap1;

    // rock at or past the bottom wraps on the next tick
    assign wrap0 = (rocks.rock0.y >= ROCK_LIMIT);
    assign wrap1 = (rocks.rock1.y >= ROCK_LIMIT);

    // one tick of motion for one rock
    function automatic rock_t fall(input rock_t r, input logic [1:0] rnd);
        rock_t n;
        if (r.y < ROCK_LIMIT) begin
            n.lane = r.lane;
            n.y    = r.y + `LG_ROCK_STEP;
        end else begin
            // back to the top in a random lane, 3 folds onto 0
            n.lane = rnd % 2'd3;
            n.y    = '0;
        end
        return n;
    endfunction

    // fibonacci lfsr, taps 7 and 5
    // free running so lanes depend on play timing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            lfsr <= `LG_LFSR_SEED;
        else
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rocks <= ROCKS_INIT;
            wave  <= 1'b0;
        end else begin
            wave <= 1'b0;
            case (state)
                START: rocks <= ROCKS_INIT;
                PLAY: begin
                    if (tick) begin
                        rocks.rock0 <= fall(rocks.rock0, lfsr[1:0]);
                        rocks.rock1 <= fall(rocks.rock1, lfsr[3:2]);
                        // single pulse even when both wrap together
                        wave <= wrap0 | wrap1;
                    end
                end
                // held still in game over
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/pixel_painter.sv ====
`include "lane_game_settings.svh"

module pixel_painter
    import lane_game_pkg::*;
(
    input  logic        bright,
    input  beam_t       beam,
    input  game_state_e state,
    input  logic        collision,
    input  coord_t      boat_x,
    input  rock_pair_t  rocks,
    output rgb_t        rgb
);

    localparam coord_t PLAYER_Y_END = `LG_PLAYER_Y_START + `LG_PLAYER_HEIGHT;

    coord_t player_left;
    coord_t player_right;
    logic   in_player;
    logic   in_rock0;
    logic   in_rock1;
    logic   in_rock;
    logic   in_sand;
    logic   crashed;

    // drawn boxes are half open, right and bottom edges excluded
    function automatic logic in_rock_box(input rock_t r, input beam_t b);
        coord_t cx;
        logic   x_in;
        logic   y_in;
        cx   = lane_center(r.lane);
        x_in = (b.h >= cx - `LG_HALF_W) && (b.h < cx + `LG_HALF_W);
        y_in = (b.v >= r.y) && (b.v < r.y + `LG_ROCK_HEIGHT);
        return x_in && y_in;
    endfunction

    assign player_left  = boat_x - `LG_HALF_W;
    assign player_right = boat_x + `LG_HALF_W;

    // boat stands in for the sprite
    assign in_player = (beam.h >= player_left) && (beam.h < player_right) &&
                       (beam.v >= `LG_PLAYER_Y_START) && (beam.v < PLAYER_Y_END);

    assign in_rock0 = in_rock_box(rocks.rock0, beam);
    assign in_rock1 = in_rock_box(rocks.rock1, beam);
    assign in_rock  = in_rock0 | in_rock1;

    // banks outside the three lanes
    assign in_sand = (beam.h < `LG_SAND_LEFT) || (beam.h >= `LG_SAND_RIGHT);

    // crash picture stays while the overlap holds
    assign crashed = (state == GAMEOVER) && collision;

    always_comb begin
        if (!bright) begin
            // blanking
            rgb = `LG_BLACK;
        end else if (crashed) begin
            if (in_player || in_rock)
                rgb = `LG_RED;
            else if (in_sand)
                rgb = `LG_SAND;
            else
                rgb = `LG_BLUE;
        end else if (in_sand) begin
            rgb = `LG_SAND;
        end else if (in_player) begin
            // boat drawn over rocks
            rgb = `LG_WHITE;
        end else if (in_rock) begin
            rgb = `LG_GREEN;
        end else begin
            // open water
            rgb = `LG_BLUE;
        end
    end

endmodule

// ==== rtl/lane_game_top.sv ====
`include "lane_game_settings.svh"

module lane_game_top
    import lane_game_pkg::*;
#(
    parameter int TICK_BITS = 22
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   bright,
    input  buttons_t               buttons,
    input  beam_t                  beam,
    output rgb_t                   rgb,
    output logic [`LG_SCORE_W-1:0] score
);

    logic        tick;
    logic        wave;
    logic        collision;
    game_state_e state;
    coord_t      boat_x;
    rock_pair_t  rocks;

    // tick, state, collision and score
    game_ctrl #(
        .TICK_BITS(TICK_BITS)
    ) game_ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .buttons  (buttons),
        .boat_x   (boat_x),
        .rocks    (rocks),
        .wave     (wave),
        .tick     (tick),
        .state    (state),
        .collision(collision),
        .score    (score)
    );

    // lane changes and sliding
    boat_steer boat_steer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .tick   (tick),
        .buttons(buttons),
        .boat_x (boat_x)
    );

    // falling rocks and wave pulse
    rock_field rock_field_i (
        .clk  (clk),
        .rst_n(rst_n),
        .state(state),
        .tick (tick),
        .rocks(rocks),
        .wave (wave)
    );

    // colour at the beam position
    pixel_painter pixel_painter_i (
        .bright   (bright),
        .beam     (beam),
        .state    (state),
        .collision(collision),
        .boat_x   (boat_x),
        .rocks    (rocks),
        .rgb      (rgb)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // low for three rising edges, let go on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== tests/lane_game_assert.sv ====
`include "lane_game_settings.svh"

module lane_game_assert
    import lane_game_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   tick,
    input logic                   wave,
    input game_state_e            state,
    input logic [`LG_SCORE_W-1:0] score
);
    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end
    int fail_count = 0;

    // slow tick is a one cycle pulse
    tick_single: assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick)
        else begin
            fail_count++;
            $error("tick high in two consecutive cycles");
        end

    // START only ever clears the score
    score_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state == START) |=> ($stable(score) || score == '0))
        else begin
            fail_count++;
            $error("score changed in START to a nonzero value");
        end

    // wave comes from a tick one cycle earlier
    wave_after_tick: assert property (@(posedge clk) disable iff (!rst_n) wave |-> $past(tick))
        else begin
            fail_count++;
            $error("wave pulsed without a tick in the previous cycle");
        end

endmodule

bind lane_game_top lane_game_assert lane_game_assert_i (
    .clk  (clk),
    .rst_n(rst_n),
    .tick (tick),
    .wave (wave),
    .state(state),
    .score(score)
);

// ==== tests/lane_game_tb.sv ====
`include "lane_game_settings.svh"

module lane_game_tb
    import lane_game_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // stimulus modes
    localparam int IDLE = 0;
    localparam int PRESS = 1;
    localparam int STEER = 2;
    localparam int HUNT = 3;
    localparam int RESTART = 4;

    logic                   clk;
    logic                   rst_n;
    logic                   bright;
    buttons_t               buttons;
    beam_t                  beam;
    rgb_t                   rgb;
    logic [`LG_SCORE_W-1:0] score;

    // cycle model of the game
    logic [2:0]             m_cnt;
    game_state_e            m_state;
    logic                   m_moving;
    int                     m_lane;
    int                     m_boat_x;
    int                     m_lane0;
    int                     m_y0;
    int                     m_lane1;
    int                     m_y1;
    logic [7:0]             m_lfsr;
    logic                   m_wave;
    logic [`LG_SCORE_W-1:0] m_score;

    logic [15:0] rng;
    // one bit per expected colour from bit 0 up, black sand blue white green red
    logic [5:0]  seen;
    // lanes where a slide came to rest
    logic [2:0]  settled;
    int          from_over;
    int          from_play;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_ok;

    tb_clock_gen clock_gen_i (
        .clk  (clk),
        .rst_n(rst_n)
    );

    lane_game_top #(
        .TICK_BITS(3)
    ) lane_game_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .bright (bright),
        .buttons(buttons),
        .beam   (beam),
        .rgb    (rgb),
        .score  (score)
    );

    // right shifting galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rng = galois_step(rng);
            v   = (v << 1) | rng[0];
        end
        return v;
    endfunction

    function automatic int lane_x(input int lane);
        case (lane)
            0: return `LG_LANE0_X;
            2: return `LG_LANE2_X;
            default: return `LG_LANE1_X;
        endcase
    endfunction

    // half open box as drawn
    function automatic logic in_box(input int cx, input int top, input int hgt,
                                    input int h, input int v);
        return h >= cx - `LG_HALF_W && h < cx + `LG_HALF_W && v >= top && v < top + hgt;
    endfunction

    // closed box overlap of one rock with the boat
    function automatic logic touches(input int lane, input int top);
        int cx;
        cx = lane_x(lane);
        return m_boat_x + `LG_HALF_W >= cx - `LG_HALF_W &&
               m_boat_x - `LG_HALF_W <= cx + `LG_HALF_W &&
               top <= `LG_PLAYER_Y_START + `LG_PLAYER_HEIGHT &&
               top + `LG_ROCK_HEIGHT >= `LG_PLAYER_Y_START;
    endfunction

    function automatic logic crashed();
        return touches(m_lane0, m_y0) || touches(m_lane1, m_y1);
    endfunction

    function automatic rgb_t expect_rgb();
        logic on_boat;
        logic on_rock;
        logic on_sand;
        on_boat = in_box(m_boat_x, `LG_PLAYER_Y_START, `LG_PLAYER_HEIGHT, beam.h, beam.v);
        on_rock = in_box(lane_x(m_lane0), m_y0, `LG_ROCK_HEIGHT, beam.h, beam.v) ||
                  in_box(lane_x(m_lane1), m_y1, `LG_ROCK_HEIGHT, beam.h, beam.v);
        on_sand = beam.h < `LG_SAND_LEFT || beam.h >= `LG_SAND_RIGHT;
        if (!bright)
            return `LG_BLACK;
        if (m_state == GAMEOVER && crashed())
            return (on_boat || on_rock) ? `LG_RED : (on_sand ? `LG_SAND : `LG_BLUE);
        if (on_sand)
            return `LG_SAND;
        if (on_boat)
            return `LG_WHITE;
        return on_rock ? `LG_GREEN : `LG_BLUE;
    endfunction

    task automatic place_start();
        m_moving = 1'b0;
        m_lane   = 1;
        m_boat_x = `LG_LANE1_X;
        m_lane0  = `LG_ROCK0_START_LANE;
        m_y0     = 0;
        m_lane1  = `LG_ROCK1_START_LANE;
        m_y1     = `LG_ROCK1_START_Y;
    endtask

    // one rising edge of the model
    task automatic advance_model();
        logic        tick;
        logic        wrap0;
        logic        wrap1;
        int          target;
        game_state_e next_state;
        tick       = (m_cnt == 3'd0);
        wrap0      = m_y0 >= `LG_SCREEN_BOTTOM + `LG_ROCK_HEIGHT;
        wrap1      = m_y1 >= `LG_SCREEN_BOTTOM + `LG_ROCK_HEIGHT;
        target     = lane_x(m_lane);
        next_state = m_state;
        case (m_state)
            START: if (buttons.centre) next_state = PLAY;
            PLAY: begin
                if (buttons.centre)
                    next_state = START;
                else if (crashed())
                    next_state = GAMEOVER;
            end
            default: if (buttons.centre) next_state = START;
        endcase
        // score follows the wave of the cycle before
        if (m_state == START)
            m_score = '0;
        else if (m_state == PLAY && m_wave)
            m_score = m_score + 1'b1;
        m_wave = 1'b0;
        if (m_state == START) begin
            place_start();
        end else if (m_state == PLAY) begin
            if (!m_moving) begin
                m_boat_x = target;
                if (buttons.left && m_lane > 0) begin
                    m_lane   = m_lane - 1;
                    m_moving = 1'b1;
                end else if (buttons.right && m_lane < 2) begin
                    m_lane   = m_lane + 1;
                    m_moving = 1'b1;
                end
            end else if (m_boat_x == target) begin
                m_moving = 1'b0;
                settled[m_lane] = 1'b1;
            end else if (tick) begin
                if (m_boat_x < target)
                    m_boat_x = m_boat_x + `LG_BOAT_STEP;
                else
                    m_boat_x = m_boat_x - `LG_BOAT_STEP;
            end
            if (tick) begin
                m_wave = wrap0 || wrap1;
                m_lane0 = wrap0 ? m_lfsr[1:0] % 3 : m_lane0;
                m_y0    = wrap0 ? 0 : m_y0 + `LG_ROCK_STEP;
                m_lane1 = wrap1 ? m_lfsr[3:2] % 3 : m_lane1;
                m_y1    = wrap1 ? 0 : m_y1 + `LG_ROCK_STEP;
            end
        end
        if (m_state == GAMEOVER && next_state == START)
            from_over++;
        if (m_state == PLAY && next_state == START)
            from_play++;
        m_lfsr  = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[5]};
        m_cnt   = m_cnt + 3'd1;
        m_state = next_state;
    endtask

    task automatic check_outputs();
        rgb_t exp;
        exp = expect_rgb();
        checks++;
        case (exp)
            `LG_BLACK: seen[0] = 1'b1;
            `LG_SAND:  seen[1] = 1'b1;
            `LG_BLUE:  seen[2] = 1'b1;
            `LG_WHITE: seen[3] = 1'b1;
            `LG_GREEN: seen[4] = 1'b1;
            default:   seen[5] = 1'b1;
        endcase
        if (rgb !== exp) begin
            errors++;
            $display("mismatch at %0d ns: rgb expected %h got %h", $time, exp, rgb);
        end
        if (score !== m_score) begin
            errors++;
            $display("mismatch at %0d ns: score expected %0d got %0d", $time, m_score, score);
        end
    endtask

    task automatic drive_inputs(input int mode);
        logic c;
        logic l;
        logic r;
        bright  = (rand_bits(3) != 0);
        beam.h  = coord_t'(`LG_H_VISIBLE_START + rand_bits(9));
        beam.v  = coord_t'(rand_bits(9));
        c       = (rand_bits(5) == 0);
        l       = (rand_bits(5) == 0);
        r       = (rand_bits(5) == 0);
        buttons = '0;
        case (mode)
            PRESS: buttons.centre = 1'b1;
            STEER: begin
                // rejoin play after a crash
                buttons.centre = c && m_state != PLAY;
                buttons.left   = l;
                buttons.right  = r;
            end
            HUNT: begin
                // gameover stays put
                buttons.centre = c && m_state == START;
                buttons.left   = l;
                buttons.right  = r;
            end
            RESTART: buttons.centre = c;
            default: ;
        endcase
    endtask

    // check and drive on the falling edge and step the model on the rising edge
    task automatic run_cycle(input int mode);
        @(negedge clk);
        check_outputs();
        drive_inputs(mode);
        @(posedge clk);
        advance_model();
    endtask

    task automatic end_test(input string name, input logic reached, input int err_before);
        tests_run++;
        if (!reached) begin
            errors++;
            $display("test %s: timed out before its condition was met", name);
        end else if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int n;
        int e0;
        int over_cycles;
        rng       = 16'd99;
        bright    = 1'b0;
        beam      = '0;
        buttons   = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        tests_ok  = 0;
        seen      = '0;
        settled   = '0;
        from_over = 0;
        from_play = 0;
        m_cnt     = '0;
        m_state   = START;
        m_lfsr    = `LG_LFSR_SEED;
        m_wave    = 1'b0;
        m_score   = '0;
        place_start();

        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst_n !== 1'b1 && n < 20);
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end
        advance_model();

        // start frame shows every colour but red
        e0 = errors;
        n  = 0;
        while (seen[4:0] != 5'h1f && n < 2000) begin
            run_cycle(IDLE);
            n++;
        end
        end_test("start_frame", seen[4:0] == 5'h1f, e0);

        // rocks fall, wrap and score
        e0 = errors;
        n  = 0;
        run_cycle(PRESS);
        while (m_score < 2 && n < 3000) begin
            run_cycle(IDLE);
            n++;
        end
        end_test("falling_rocks", m_score >= 2, e0);

        // slides end on both outer lanes and the middle
        e0 = errors;
        n  = 0;
        settled = '0;
        while (settled != 3'b111 && n < 30000) begin
            run_cycle(STEER);
            n++;
        end
        end_test("steering", settled == 3'b111, e0);

        // crash into a rock and sit frozen in red
        e0          = errors;
        n           = 0;
        over_cycles = 0;
        seen[5]     = 1'b0;
        while (!(over_cycles >= 40 && seen[5]) && n < 30000) begin
            run_cycle(HUNT);
            n++;
            if (m_state == GAMEOVER)
                over_cycles++;
        end
        end_test("game_over", over_cycles >= 40 && seen[5], e0);

        // centre from gameover and from play back to start
        e0        = errors;
        n         = 0;
        from_over = 0;
        from_play = 0;
        while ((from_over == 0 || from_play == 0) && n < 5000) begin
            run_cycle(RESTART);
            n++;
        end
        end_test("restart", from_over > 0 && from_play > 0, e0);

        errors = errors + lane_game_top_i.lane_game_assert_i.fail_count;
        $display("tests passed %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_ok, tests_run, checks, errors,
                 lane_game_top_i.lane_game_assert_i.fail_count);
        if (errors == 0 && tests_ok == tests_run)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== lane_game_top.f ====
+incdir+rtl
rtl/lane_game_pkg.sv
rtl/game_ctrl.sv
rtl/boat_steer.sv
rtl/rock_field.sv
rtl/pixel_painter.sv
rtl/lane_game_top.sv
tests/tb_clock_gen.sv
tests/lane_game_assert.sv
tests/lane_game_tb.sv

// ==== Bender.yml ====
package:
  name: lane_game

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lane_game_pkg.sv
      - rtl/game_ctrl.sv
      - rtl/boat_steer.sv
      - rtl/rock_field.sv
      - rtl/pixel_painter.sv
      - rtl/lane_game_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/lane_game_assert.sv
      - tests/lane_game_tb.sv
